// ==== logic/dma_regmap_pkg.sv ====
`default_nettype none

package dma_regmap_pkg;

    // register bus
    typedef logic [15:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // packet counter
    typedef logic [31:0] count_t;

    // global blocks
    localparam reg_addr_t ENABLE_ADDR  = 16'h0000;
    localparam reg_addr_t RD_CHAN_BASE = 16'h0100;
    localparam reg_addr_t WR_CHAN_BASE = 16'h0200;
    localparam reg_addr_t COUNT_BASE   = 16'h0400;

    // offsets inside a descriptor channel
    localparam reg_addr_t DESC_PCIE_LO = 16'h0000;
    localparam reg_addr_t DESC_PCIE_HI = 16'h0004;
    localparam reg_addr_t DESC_AXI     = 16'h0008;
    localparam reg_addr_t DESC_LEN     = 16'h0010;
    localparam reg_addr_t DESC_TAG     = 16'h0014;
    localparam reg_addr_t DESC_STATUS  = 16'h0018;

    // status word layout
    localparam int STATUS_VALID_BIT = 31;

endpackage

`default_nettype wire

// ==== logic/dma_desc_pkg.sv ====
`default_nettype none

package dma_desc_pkg;

    // host side address
    typedef logic [63:0] pcie_addr_t;

    // local memory address
    typedef logic [31:0] axi_addr_t;

    // transfer length in bytes
    typedef logic [15:0] dma_len_t;

    typedef logic [7:0] dma_tag_t;

endpackage

`default_nettype wire

// ==== logic/ctrl_axil_slave.sv ====
`default_nettype none

module ctrl_axil_slave (
    input  wire                            clk,
    input  wire                            rst,
    input  wire dma_regmap_pkg::reg_addr_t awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire dma_regmap_pkg::reg_data_t wdata,
    input  wire                            wvalid,
    output logic                           wready,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire dma_regmap_pkg::reg_addr_t araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output dma_regmap_pkg::reg_data_t      rdata,
    output logic                           rvalid,
    input  wire                            rready,
    output logic                           reg_wr,
    output dma_regmap_pkg::reg_addr_t      reg_wr_addr,
    output dma_regmap_pkg::reg_data_t      reg_wr_data,
    output logic                           reg_rd,
    output dma_regmap_pkg::reg_addr_t      reg_rd_addr,
    input  wire dma_regmap_pkg::reg_data_t rd_chan_data,
    input  wire dma_regmap_pkg::reg_data_t wr_chan_data,
    input  wire dma_regmap_pkg::reg_data_t count_data,
    output logic                           dma_enable
);
    import dma_regmap_pkg::*;

    reg_data_t enable_data;

    // accept only with the previous response gone
    assign reg_wr      = awvalid && wvalid && !bvalid;
    assign reg_wr_addr = {awaddr[15:2], 2'b00};
    assign reg_wr_data = wdata;

    assign reg_rd      = arvalid && !rvalid;
    assign reg_rd_addr = {araddr[15:2], 2'b00};

    assign enable_data = (reg_rd_addr == ENABLE_ADDR) ? reg_data_t'(dma_enable) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            bvalid     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            dma_enable <= 1'b0;
        end else begin
            awready <= reg_wr;
            wready  <= reg_wr;
            bvalid  <= (bvalid && !bready) || reg_wr;
            arready <= reg_rd;
            rvalid  <= (rvalid && !rready) || reg_rd;
            if (reg_wr && reg_wr_addr == ENABLE_ADDR) begin
                dma_enable <= reg_wr_data[0];
            end
        end
    end

    // unaddressed blocks return zero, so a plain OR selects
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            rdata <= rd_chan_data | wr_chan_data | count_data | enable_data;
        end
    end

    // a waiting response holds and blocks the next request
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && !awready && !wready);
    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && !arready);

endmodule

`default_nettype wire

// ==== logic/dma_desc_channel.sv ====
`default_nettype none

module dma_desc_channel #(
    parameter dma_regmap_pkg::reg_addr_t CHAN_BASE = dma_regmap_pkg::RD_CHAN_BASE
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            reg_wr,
    input  wire dma_regmap_pkg::reg_addr_t reg_wr_addr,
    input  wire dma_regmap_pkg::reg_data_t reg_wr_data,
    input  wire                            reg_rd,
    input  wire dma_regmap_pkg::reg_addr_t reg_rd_addr,
    output dma_regmap_pkg::reg_data_t      reg_rd_data,
    output dma_desc_pkg::pcie_addr_t       desc_pcie_addr,
    output dma_desc_pkg::axi_addr_t        desc_axi_addr,
    output dma_desc_pkg::dma_len_t         desc_len,
    output dma_desc_pkg::dma_tag_t         desc_tag,
    output logic                           desc_valid,
    input  wire                            desc_ready,
    input  wire dma_desc_pkg::dma_tag_t    status_tag,
    input  wire                            status_valid,
    output logic                           status_ready
);
    import dma_regmap_pkg::*;
    import dma_desc_pkg::*;

    localparam reg_addr_t PCIE_LO_ADDR = CHAN_BASE + DESC_PCIE_LO;
    localparam reg_addr_t PCIE_HI_ADDR = CHAN_BASE + DESC_PCIE_HI;
    localparam reg_addr_t AXI_ADDR     = CHAN_BASE + DESC_AXI;
    localparam reg_addr_t LEN_ADDR     = CHAN_BASE + DESC_LEN;
    localparam reg_addr_t TAG_ADDR     = CHAN_BASE + DESC_TAG;
    localparam reg_addr_t STATUS_ADDR  = CHAN_BASE + DESC_STATUS;

    logic tag_wr;
    logic status_rd;

    assign tag_wr    = reg_wr && (reg_wr_addr == TAG_ADDR);
    assign status_rd = reg_rd && (reg_rd_addr == STATUS_ADDR);

    // fields frozen while the descriptor is offered
    always_ff @(posedge clk) begin
        if (reg_wr && !desc_valid) begin
            case (reg_wr_addr)
                PCIE_LO_ADDR: desc_pcie_addr[31:0] <= reg_wr_data;
                PCIE_HI_ADDR: desc_pcie_addr[63:32] <= reg_wr_data;
                AXI_ADDR:     desc_axi_addr <= axi_addr_t'(reg_wr_data);
                LEN_ADDR:     desc_len <= dma_len_t'(reg_wr_data);
                default:      ;
            endcase
        end
        if (tag_wr) begin
            desc_tag <= dma_tag_t'(reg_wr_data);
        end
    end

    // tag write launches the descriptor
    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid   <= 1'b0;
            status_ready <= 1'b0;
        end else begin
            desc_valid   <= (desc_valid && !desc_ready) || tag_wr;
            status_ready <= status_rd && status_valid;
        end
    end

    always_comb begin
        reg_rd_data = '0;
        if (status_rd) begin
            reg_rd_data[STATUS_VALID_BIT] = status_valid;
            reg_rd_data[$bits(dma_tag_t)-1:0] = status_tag;
        end
    end

    // one status read pops for a single cycle only
    assert property (@(posedge clk) disable iff (rst) status_ready |=> !status_ready);

endmodule

`default_nettype wire

// ==== logic/tlp_counters.sv ====
`default_nettype none

module tlp_counters (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rq_valid,
    input  wire                            rq_ready,
    input  wire                            rq_last,
    input  wire                            rc_valid,
    input  wire                            rc_ready,
    input  wire                            rc_last,
    input  wire                            cq_valid,
    input  wire                            cq_ready,
    input  wire                            cq_last,
    input  wire                            cc_valid,
    input  wire                            cc_ready,
    input  wire                            cc_last,
    input  wire dma_regmap_pkg::reg_addr_t reg_rd_addr,
    output dma_regmap_pkg::reg_data_t      reg_rd_data
);
    import dma_regmap_pkg::*;

    logic [3:0] pkt_end;
    count_t     count [4];

    // order matches the register layout: rq, rc, cq, cc
    assign pkt_end = {cc_valid && cc_ready && cc_last,
                      cq_valid && cq_ready && cq_last,
                      rc_valid && rc_ready && rc_last,
                      rq_valid && rq_ready && rq_last};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst) begin
                count[i] <= '0;
            end else if (pkt_end[i]) begin
                count[i] <= count[i] + 1'b1;
            end
        end
    end

    always_comb begin
        reg_rd_data = '0;
        for (int i = 0; i < 4; i++) begin
            if (reg_rd_addr == COUNT_BASE + reg_addr_t'(4 * i)) begin
                reg_rd_data = count[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/error_pulse_merge.sv ====
`default_nettype none

module error_pulse_merge #(
    parameter int SOURCES     = 3,
    parameter int COUNT_WIDTH = 4
) (
    input  wire               clk,
    input  wire               rst,
    input  wire [SOURCES-1:0] pulse_in,
    output logic              err_out
);
    localparam int SUM_WIDTH = COUNT_WIDTH + $clog2(SOURCES + 1);
    localparam logic [COUNT_WIDTH-1:0] COUNT_MAX = '1;

    logic [COUNT_WIDTH-1:0] pending;
    logic [SUM_WIDTH-1:0]   arrivals;
    logic [SUM_WIDTH-1:0]   sum;

    // one output pulse per pending count
    assign err_out = pending != '0;

    always_comb begin
        arrivals = '0;
        for (int i = 0; i < SOURCES; i++) begin
            arrivals = arrivals + SUM_WIDTH'(pulse_in[i]);
        end
        sum = SUM_WIDTH'(pending) + arrivals - SUM_WIDTH'(err_out);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else if (sum > SUM_WIDTH'(COUNT_MAX)) begin
            pending <= COUNT_MAX;
        end else begin
            pending <= pending[COUNT_WIDTH-1:0] + arrivals[COUNT_WIDTH-1:0] - err_out;
        end
    end

    // saturates instead of wrapping, so it never falls by more than one
    assert property (@(posedge clk) disable iff (rst)
        {1'b0, pending} + 1'b1 >= {1'b0, $past(pending)});

endmodule

`default_nettype wire

// ==== logic/dma_ctrl_top.sv ====
`default_nettype none

module dma_ctrl_top #(
    parameter int ERR_SOURCES     = 3,
    parameter int ERR_COUNT_WIDTH = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire dma_regmap_pkg::reg_addr_t awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire dma_regmap_pkg::reg_data_t wdata,
    input  wire                            wvalid,
    output logic                           wready,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire dma_regmap_pkg::reg_addr_t araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output dma_regmap_pkg::reg_data_t      rdata,
    output logic                           rvalid,
    input  wire                            rready,
    output dma_desc_pkg::pcie_addr_t       rd_desc_pcie_addr,
    output dma_desc_pkg::axi_addr_t        rd_desc_axi_addr,
    output dma_desc_pkg::dma_len_t         rd_desc_len,
    output dma_desc_pkg::dma_tag_t         rd_desc_tag,
    output logic                           rd_desc_valid,
    input  wire                            rd_desc_ready,
    input  wire dma_desc_pkg::dma_tag_t    rd_status_tag,
    input  wire                            rd_status_valid,
    output logic                           rd_status_ready,
    output dma_desc_pkg::pcie_addr_t       wr_desc_pcie_addr,
    output dma_desc_pkg::axi_addr_t        wr_desc_axi_addr,
    output dma_desc_pkg::dma_len_t         wr_desc_len,
    output dma_desc_pkg::dma_tag_t         wr_desc_tag,
    output logic                           wr_desc_valid,
    input  wire                            wr_desc_ready,
    input  wire dma_desc_pkg::dma_tag_t    wr_status_tag,
    input  wire                            wr_status_valid,
    output logic                           wr_status_ready,
    output logic                           dma_enable,
    input  wire                            rq_valid,
    input  wire                            rq_ready,
    input  wire                            rq_last,
    input  wire                            rc_valid,
    input  wire                            rc_ready,
    input  wire                            rc_last,
    input  wire                            cq_valid,
    input  wire                            cq_ready,
    input  wire                            cq_last,
    input  wire                            cc_valid,
    input  wire                            cc_ready,
    input  wire                            cc_last,
    input  wire [ERR_SOURCES-1:0]          err_cor_in,
    input  wire [ERR_SOURCES-1:0]          err_uncor_in,
    output logic                           err_cor,
    output logic                           err_uncor
);
    import dma_regmap_pkg::*;

    logic      reg_wr;
    reg_addr_t reg_wr_addr;
    reg_data_t reg_wr_data;
    logic      reg_rd;
    reg_addr_t reg_rd_addr;
    reg_data_t rd_chan_data;
    reg_data_t wr_chan_data;
    reg_data_t count_data;

    ctrl_axil_slave u_slave (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rvalid, .rready,
        .reg_wr, .reg_wr_addr, .reg_wr_data, .reg_rd, .reg_rd_addr,
        .rd_chan_data, .wr_chan_data, .count_data, .dma_enable
    );

    dma_desc_channel #(.CHAN_BASE(RD_CHAN_BASE)) u_rd_chan (
        .clk, .rst,
        .reg_wr, .reg_wr_addr, .reg_wr_data, .reg_rd, .reg_rd_addr,
        .reg_rd_data    (rd_chan_data),
        .desc_pcie_addr (rd_desc_pcie_addr),
        .desc_axi_addr  (rd_desc_axi_addr),
        .desc_len       (rd_desc_len),
        .desc_tag       (rd_desc_tag),
        .desc_valid     (rd_desc_valid),
        .desc_ready     (rd_desc_ready),
        .status_tag     (rd_status_tag),
        .status_valid   (rd_status_valid),
        .status_ready   (rd_status_ready)
    );

    dma_desc_channel #(.CHAN_BASE(WR_CHAN_BASE)) u_wr_chan (
        .clk, .rst,
        .reg_wr, .reg_wr_addr, .reg_wr_data, .reg_rd, .reg_rd_addr,
        .reg_rd_data    (wr_chan_data),
        .desc_pcie_addr (wr_desc_pcie_addr),
        .desc_axi_addr  (wr_desc_axi_addr),
        .desc_len       (wr_desc_len),
        .desc_tag       (wr_desc_tag),
        .desc_valid     (wr_desc_valid),
        .desc_ready     (wr_desc_ready),
        .status_tag     (wr_status_tag),
        .status_valid   (wr_status_valid),
        .status_ready   (wr_status_ready)
    );

    tlp_counters u_counters (
        .clk, .rst,
        .rq_valid, .rq_ready, .rq_last, .rc_valid, .rc_ready, .rc_last,
        .cq_valid, .cq_ready, .cq_last, .cc_valid, .cc_ready, .cc_last,
        .reg_rd_addr,
        .reg_rd_data (count_data)
    );

    error_pulse_merge #(.SOURCES(ERR_SOURCES), .COUNT_WIDTH(ERR_COUNT_WIDTH)) u_err_cor (
        .clk, .rst,
        .pulse_in (err_cor_in),
        .err_out  (err_cor)
    );

    error_pulse_merge #(.SOURCES(ERR_SOURCES), .COUNT_WIDTH(ERR_COUNT_WIDTH)) u_err_uncor (
        .clk, .rst,
        .pulse_in (err_uncor_in),
        .err_out  (err_uncor)
    );

endmodule

`default_nettype wire

// ==== tb/tb_dma_ctrl.sv ====
`default_nettype none

module tb_dma_ctrl;
    import dma_regmap_pkg::*;
    import dma_desc_pkg::*;

    localparam int OP_WR      = 0;
    localparam int OP_RD      = 1;
    localparam int OP_ENABLE  = 2;
    localparam int OP_DESC    = 3;
    localparam int OP_STATUS  = 4;
    localparam int OP_STREAMS = 5;
    localparam int OP_COUNT   = 6;
    localparam int OP_ERRORS  = 7;

    localparam pcie_addr_t RD_PCIE = 64'h0000_00ab_cdef_1000;
    localparam axi_addr_t  RD_AXI  = 32'h0000_4000;
    localparam dma_len_t   RD_LEN  = 16'h0200;
    localparam dma_tag_t   RD_TAG  = 8'h15;
    localparam pcie_addr_t WR_PCIE = 64'h0000_0123_0000_8000;
    localparam axi_addr_t  WR_AXI  = 32'h0001_0000;
    localparam dma_len_t   WR_LEN  = 16'h0080;
    localparam dma_tag_t   WR_TAG  = 8'h2a;

    logic clk, rst;
    reg_addr_t awaddr, araddr;
    reg_data_t wdata, rdata;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready, dma_enable;
    pcie_addr_t rd_desc_pcie_addr, wr_desc_pcie_addr;
    axi_addr_t rd_desc_axi_addr, wr_desc_axi_addr;
    dma_len_t rd_desc_len, wr_desc_len;
    dma_tag_t rd_desc_tag, wr_desc_tag, rd_status_tag, wr_status_tag;
    logic rd_desc_valid, rd_desc_ready, rd_status_valid, rd_status_ready;
    logic wr_desc_valid, wr_desc_ready, wr_status_valid, wr_status_ready;
    logic rq_valid, rq_ready, rq_last, rc_valid, rc_ready, rc_last;
    logic cq_valid, cq_ready, cq_last, cc_valid, cc_ready, cc_last;
    logic [2:0] err_cor_in, err_uncor_in;
    logic err_cor, err_uncor;

    // stimulus table: operation, address, write data, expected value
    int        tbl_op[$];
    reg_addr_t tbl_addr[$];
    reg_data_t tbl_data[$];
    reg_data_t tbl_exp[$];

    int errors = 0;
    int cycles = 0;
    int limit = 0;
    int stream_count[4] = '{0, 0, 0, 0};
    int rd_pops = 0;
    int wr_pops = 0;
    int cor_seen = 0;
    int uncor_seen = 0;

    dma_ctrl_top #(.ERR_SOURCES(3), .ERR_COUNT_WIDTH(4)) u_dut (.*);

    always #20 clk = ~clk;

    // one-cycle outputs, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst) begin
            rd_pops    <= rd_pops + int'(rd_status_ready);
            wr_pops    <= wr_pops + int'(wr_status_ready);
            cor_seen   <= cor_seen + int'(err_cor);
            uncor_seen <= uncor_seen + int'(err_uncor);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: tests still running after %0d cycles", limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    function automatic void add_entry(input int op, input reg_addr_t addr,
                                      input reg_data_t data, input reg_data_t exp);
        tbl_op.push_back(op);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_exp.push_back(exp);
    endfunction

    // field writes, idle check, tag write, then the launch check
    function automatic void load_descriptor(input reg_addr_t base, input pcie_addr_t pcie,
                                            input axi_addr_t axi, input dma_len_t len,
                                            input dma_tag_t tag);
        add_entry(OP_WR, base + DESC_PCIE_LO, pcie[31:0], 0);
        add_entry(OP_WR, base + DESC_PCIE_HI, pcie[63:32], 0);
        add_entry(OP_WR, base + DESC_AXI, axi, 0);
        add_entry(OP_WR, base + DESC_LEN, reg_data_t'(len), 0);
        add_entry(OP_DESC, base, 0, 0);
        add_entry(OP_WR, base + DESC_TAG, reg_data_t'(tag), 0);
        add_entry(OP_DESC, base, 0, 1);
    endfunction

    function automatic void build_table();
        add_entry(OP_RD, ENABLE_ADDR, 0, 0);
        add_entry(OP_RD, RD_CHAN_BASE + DESC_STATUS, 0, 0);
        add_entry(OP_RD, WR_CHAN_BASE + DESC_STATUS, 0, 0);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_RD, COUNT_BASE + reg_addr_t'(4 * i), 0, 0);
        end
        add_entry(OP_WR, ENABLE_ADDR, 1, 0);
        add_entry(OP_ENABLE, ENABLE_ADDR, 0, 1);
        add_entry(OP_RD, ENABLE_ADDR, 0, 1);
        load_descriptor(RD_CHAN_BASE, RD_PCIE, RD_AXI, RD_LEN, RD_TAG);
        load_descriptor(WR_CHAN_BASE, WR_PCIE, WR_AXI, WR_LEN, WR_TAG);
        add_entry(OP_STATUS, RD_CHAN_BASE + DESC_STATUS, 1, 0);
        add_entry(OP_STATUS, WR_CHAN_BASE + DESC_STATUS, 0, 0);
        add_entry(OP_STREAMS, 0, 100, 0);
        for (int i = 0; i < 4; i++) begin
            add_entry(OP_COUNT, COUNT_BASE + reg_addr_t'(4 * i), 0, 0);
        end
        add_entry(OP_ERRORS, 0, 6, 0);
    endfunction

    task automatic axil_write(input reg_addr_t addr, input reg_data_t data);
        int delay;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // address and data taken on the edge that raised bvalid
        check_value("awready", awready, 1);
        check_value("wready", wready, 1);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        check_value("bvalid", bvalid, 1);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value("bvalid", bvalid, 0);
        check_value("awready", awready, 0);
        check_value("wready", wready, 0);
    endtask

    task automatic axil_read(input reg_addr_t addr, output reg_data_t data);
        int delay;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        check_value("arready", arready, 1);
        arvalid = 1'b0;
        data = rdata;
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge clk);
        check_value("rvalid", rvalid, 1);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        check_value("rvalid", rvalid, 0);
        check_value("arready", arready, 0);
    endtask

    function automatic logic valid_of(input bit wr_chan);
        return wr_chan ? wr_desc_valid : rd_desc_valid;
    endfunction

    task automatic check_descriptor(input bit wr_chan, input bit launched);
        string pfx;
        pfx = wr_chan ? "wr_" : "rd_";
        check_value({pfx, "desc_valid"}, valid_of(wr_chan), launched);
        if (launched) begin
            check_value({pfx, "desc_pcie_addr"},
                        wr_chan ? wr_desc_pcie_addr : rd_desc_pcie_addr,
                        wr_chan ? WR_PCIE : RD_PCIE);
            check_value({pfx, "desc_axi_addr"},
                        wr_chan ? wr_desc_axi_addr : rd_desc_axi_addr,
                        wr_chan ? WR_AXI : RD_AXI);
            check_value({pfx, "desc_len"}, wr_chan ? wr_desc_len : rd_desc_len,
                        wr_chan ? WR_LEN : RD_LEN);
            check_value({pfx, "desc_tag"}, wr_chan ? wr_desc_tag : rd_desc_tag,
                        wr_chan ? WR_TAG : RD_TAG);
            // the read channel's ready must not release the write channel
            rd_desc_ready = wr_chan;
            repeat (5) begin
                @(negedge clk);
                check_value({pfx, "desc_valid"}, valid_of(wr_chan), 1);
            end
            rd_desc_ready = 1'b1;
            wr_desc_ready = wr_chan;
            @(negedge clk);
            rd_desc_ready = 1'b0;
            wr_desc_ready = 1'b0;
            check_value({pfx, "desc_valid"}, valid_of(wr_chan), 0);
        end
    endtask

    task automatic check_status(input reg_addr_t addr, input bit drive);
        bit        wr_chan;
        dma_tag_t  tag;
        int        pops_before;
        reg_data_t got;
        string     pfx;
        wr_chan = addr == WR_CHAN_BASE + DESC_STATUS;
        pfx = wr_chan ? "wr_" : "rd_";
        // an idle engine presents no tag
        tag = drive ? dma_tag_t'($urandom_range(255, 0)) : '0;
        if (wr_chan) begin
            wr_status_tag   = tag;
            wr_status_valid = drive;
            pops_before     = wr_pops;
        end else begin
            rd_status_tag   = tag;
            rd_status_valid = drive;
            pops_before     = rd_pops;
        end
        axil_read(addr, got);
        repeat (2) @(negedge clk);
        check_value($sformatf("rdata[%h]", addr), got,
                    drive ? (32'h1 << STATUS_VALID_BIT) | 32'(tag) : 32'h0);
        check_value({pfx, "status_ready pulses"},
                    (wr_chan ? wr_pops : rd_pops) - pops_before, drive);
        rd_status_valid = 1'b0;
        wr_status_valid = 1'b0;
    endtask

    // a packet ends where valid, ready and last are all high
    task automatic drive_streams(input int beats);
        logic [11:0] s;
        for (int c = 0; c <= beats; c++) begin
            s = (c < beats) ? 12'($urandom) : 12'h0;
            {rq_valid, rq_ready, rq_last, rc_valid, rc_ready, rc_last,
             cq_valid, cq_ready, cq_last, cc_valid, cc_ready, cc_last} = s;
            for (int i = 0; i < 4; i++) begin
                if (&s[11 - 3 * i -: 3]) stream_count[i]++;
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_errors(input int rounds);
        int cor_sent;
        int uncor_sent;
        cor_sent = 0;
        uncor_sent = 0;
        for (int r = 0; r < rounds; r++) begin
            // at most 9 pulses per burst, under the saturation count
            for (int c = 0; c < 3; c++) begin
                err_cor_in   = 3'($urandom);
                err_uncor_in = 3'($urandom);
                cor_sent   += $countones(err_cor_in);
                uncor_sent += $countones(err_uncor_in);
                @(negedge clk);
            end
            err_cor_in   = '0;
            err_uncor_in = '0;
            repeat (20) @(negedge clk);
        end
        check_value("err_cor", err_cor, 0);
        check_value("err_uncor", err_uncor, 0);
        check_value("err_cor pulses", cor_seen, cor_sent);
        check_value("err_uncor pulses", uncor_seen, uncor_sent);
    endtask

    task automatic run_entry(input int idx);
        reg_data_t got;
        case (tbl_op[idx])
            OP_WR: axil_write(tbl_addr[idx], tbl_data[idx]);
            OP_RD: begin
                axil_read(tbl_addr[idx], got);
                check_value($sformatf("rdata[%h]", tbl_addr[idx]), got, tbl_exp[idx]);
            end
            OP_ENABLE: check_value("dma_enable", dma_enable, tbl_exp[idx]);
            OP_DESC: check_descriptor(tbl_addr[idx] == WR_CHAN_BASE, tbl_exp[idx][0]);
            OP_STATUS: check_status(tbl_addr[idx], tbl_data[idx][0]);
            OP_STREAMS: drive_streams(tbl_data[idx]);
            OP_COUNT: begin
                axil_read(tbl_addr[idx], got);
                check_value($sformatf("rdata[%h]", tbl_addr[idx]), got,
                            stream_count[(tbl_addr[idx] - COUNT_BASE) >> 2]);
            end
            OP_ERRORS: drive_errors(tbl_data[idx]);
            default: ;
        endcase
    endtask

    initial begin
        void'($urandom(32'hec4e_a908));
        clk = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rd_desc_ready = 1'b0;
        rd_status_tag = '0;
        rd_status_valid = 1'b0;
        wr_desc_ready = 1'b0;
        wr_status_tag = '0;
        wr_status_valid = 1'b0;
        {rq_valid, rq_ready, rq_last, rc_valid, rc_ready, rc_last,
         cq_valid, cq_ready, cq_last, cc_valid, cc_ready, cc_last} = '0;
        err_cor_in = '0;
        err_uncor_in = '0;
        build_table();
        limit = 40 * tbl_op.size() + 400;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < tbl_op.size(); i++) begin
            run_entry(i);
        end
        $display("%0d errors in %0d table entries", errors, tbl_op.size());
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/dma_regmap_pkg.sv
logic/dma_desc_pkg.sv
logic/ctrl_axil_slave.sv
logic/dma_desc_channel.sv
logic/tlp_counters.sv
logic/error_pulse_merge.sv
logic/dma_ctrl_top.sv
tb/tb_dma_ctrl.sv
